// ==== src/i2c_pkg.sv ====
package i2c_pkg;

    // Bus timing
    localparam int unsigned clk_freq    = 32'd50_000_000; // System clock in Hz
    localparam int unsigned scl_freq    = 32'd100_000;    // SCL rate in Hz
    localparam int unsigned quarter_div = clk_freq / (4 * scl_freq);

    // Divider count for one quarter bit
    typedef logic [7:0] div_cnt_t;

    // Quarter-bit position inside a bit slot
    typedef logic [1:0] phase_t;

    localparam phase_t ph_low  = 2'd0; // SCL low, data changes
    localparam phase_t ph_rise = 2'd1; // SCL rises
    localparam phase_t ph_high = 2'd2; // SCL high, sample point
    localparam phase_t ph_fall = 2'd3; // SCL falls

    typedef logic [6:0] slave_addr_t;
    typedef logic [7:0] data_byte_t;
    typedef logic [2:0] bit_cnt_t;

    // What the line driver puts on the bus for the current slot
    typedef enum logic [1:0] {
        cond_idle,
        cond_start,
        cond_bit,
        cond_stop
    } bus_cond_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_addr,
        st_addr_ack,
        st_wdata,
        st_wdata_ack,
        st_rdata,
        st_rdata_nack,
        st_stop
    } seq_state_t;

endpackage

// ==== src/i2c_bit_timer.sv ====
`timescale 1ns/100ps

module i2c_bit_timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,   // High for the whole transaction
    output logic            tick,  // One clock at the end of each quarter bit
    output i2c_pkg::phase_t phase
);

    i2c_pkg::div_cnt_t div_cnt;
    logic              div_wrap;

    // Last clock of the current quarter bit
    assign div_wrap = (div_cnt == i2c_pkg::div_cnt_t'(i2c_pkg::quarter_div - 1));

    assign tick = run && div_wrap;

    // Quarter-bit divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (!run) begin
            div_cnt <= '0; // Hold at zero between transactions
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Phase steps once per tick and wraps after ph_fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= i2c_pkg::ph_low;
        end else if (!run) begin
            phase <= i2c_pkg::ph_low;
        end else if (tick) begin
            phase <= phase + 2'd1;
        end
    end

endmodule

// ==== src/i2c_byte_sequencer.sv ====
`timescale 1ns/100ps

module i2c_byte_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,      // One-cycle request, taken only when idle
    input  logic                  rw,         // 1 for read
    input  i2c_pkg::slave_addr_t  slave_addr,
    input  i2c_pkg::data_byte_t   wdata,
    input  logic                  tick,
    input  i2c_pkg::phase_t       phase,
    input  logic                  sda_in,     // Synchronized bus data
    output logic                  run,
    output i2c_pkg::bus_cond_t    cond,
    output logic                  tx_bit,     // 1 releases SDA
    output i2c_pkg::data_byte_t   rdata,
    output logic                  busy,
    output logic                  done,
    output logic                  ack_error
);

    i2c_pkg::seq_state_t state;
    i2c_pkg::data_byte_t shift_reg; // Address+rw, then write data
    i2c_pkg::data_byte_t wdata_q;
    i2c_pkg::bit_cnt_t   bit_cnt;
    logic                rw_q;
    logic                accept;
    logic                sample;
    logic                slot_end;

    assign accept   = (state == i2c_pkg::st_idle) && start;
    assign sample   = tick && (phase == i2c_pkg::ph_high);
    assign slot_end = tick && (phase == i2c_pkg::ph_fall);

    assign busy = (state != i2c_pkg::st_idle);
    assign run  = busy;

    // Bus request for the current slot
    always_comb begin
        case (state)
            i2c_pkg::st_idle:  cond = i2c_pkg::cond_idle;
            i2c_pkg::st_start: cond = i2c_pkg::cond_start;
            i2c_pkg::st_stop:  cond = i2c_pkg::cond_stop;
            default:           cond = i2c_pkg::cond_bit;
        endcase
    end

    // Only address and write data bits are driven by the master
    always_comb begin
        if (state == i2c_pkg::st_addr || state == i2c_pkg::st_wdata) begin
            tx_bit = shift_reg[7];
        end else begin
            tx_bit = 1'b1; // Ack slots, read data and the read NACK
        end
    end

    // Transaction state, bit counter and status
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= i2c_pkg::st_idle;
            bit_cnt   <= 3'd7;
            done      <= 1'b0;
            ack_error <= 1'b0;
            rdata     <= '0;
        end else begin
            done <= 1'b0;

            if (accept) begin
                state     <= i2c_pkg::st_start;
                ack_error <= 1'b0; // Fresh status per transaction
            end

            // Slave answers in both ack slots, high means NACK
            if (sample && sda_in &&
                (state == i2c_pkg::st_addr_ack || state == i2c_pkg::st_wdata_ack)) begin
                ack_error <= 1'b1;
            end

            if (sample && state == i2c_pkg::st_rdata) begin
                rdata <= {rdata[6:0], sda_in}; // MSB first
            end

            if (slot_end) begin
                case (state)
                    i2c_pkg::st_start: begin
                        state   <= i2c_pkg::st_addr;
                        bit_cnt <= 3'd7;
                    end
                    i2c_pkg::st_addr: begin
                        if (bit_cnt == 3'd0) begin
                            state <= i2c_pkg::st_addr_ack;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                    i2c_pkg::st_addr_ack: begin
                        bit_cnt <= 3'd7;
                        if (ack_error) begin
                            state <= i2c_pkg::st_stop; // No slave, skip the data byte
                        end else if (rw_q) begin
                            state <= i2c_pkg::st_rdata;
                        end else begin
                            state <= i2c_pkg::st_wdata;
                        end
                    end
                    i2c_pkg::st_wdata: begin
                        if (bit_cnt == 3'd0) begin
                            state <= i2c_pkg::st_wdata_ack;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                    i2c_pkg::st_wdata_ack: state <= i2c_pkg::st_stop;
                    i2c_pkg::st_rdata: begin
                        if (bit_cnt == 3'd0) begin
                            state <= i2c_pkg::st_rdata_nack;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                    i2c_pkg::st_rdata_nack: state <= i2c_pkg::st_stop;
                    i2c_pkg::st_stop: begin
                        state <= i2c_pkg::st_idle;
                        done  <= 1'b1; // Same cycle busy drops
                    end
                    default: state <= i2c_pkg::st_idle;
                endcase
            end
        end
    end

    // Request capture and transmit shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= {slave_addr, rw};
            wdata_q   <= wdata;
            rw_q      <= rw;
        end else if (slot_end) begin
            if (state == i2c_pkg::st_addr_ack) begin
                shift_reg <= wdata_q;
            end else if (state == i2c_pkg::st_addr || state == i2c_pkg::st_wdata) begin
                shift_reg <= {shift_reg[6:0], 1'b0};
            end
        end
    end

endmodule

// ==== src/i2c_line_driver.sv ====
`timescale 1ns/100ps

module i2c_line_driver (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::bus_cond_t cond,
    input  i2c_pkg::phase_t    phase,
    input  logic               tx_bit,  // 1 releases SDA
    output logic               scl,
    inout  wire                sda,
    output logic               sda_in
);

    logic       sda_low;  // Pull-down request for the open-drain SDA
    logic [1:0] sda_sync;

    assign sda = sda_low ? 1'b0 : 1'bz;

    // Registered line levels per request and phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end else begin
            case (cond)
                i2c_pkg::cond_start: begin
                    scl     <= 1'b1;
                    // SDA falls halfway through with SCL held high
                    sda_low <= (phase == i2c_pkg::ph_high || phase == i2c_pkg::ph_fall);
                end
                i2c_pkg::cond_bit: begin
                    scl <= (phase == i2c_pkg::ph_rise || phase == i2c_pkg::ph_high);
                    // Data may only move once SCL is already low
                    if (!scl) begin
                        sda_low <= !tx_bit;
                    end
                end
                i2c_pkg::cond_stop: begin
                    scl     <= (phase != i2c_pkg::ph_low);
                    sda_low <= (phase == i2c_pkg::ph_low || phase == i2c_pkg::ph_rise);
                end
                default: begin
                    scl     <= 1'b1; // Bus idle, both lines released
                    sda_low <= 1'b0;
                end
            endcase
        end
    end

    // Two-flop synchronizer on the returned data line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sda_sync <= 2'b11;
        end else begin
            sda_sync <= {sda_sync[0], sda};
        end
    end

    assign sda_in = sda_sync[1];

endmodule

// ==== src/i2c_master_top.sv ====
`timescale 1ns/100ps

module i2c_master_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 rw,
    input  i2c_pkg::slave_addr_t slave_addr,
    input  i2c_pkg::data_byte_t  wdata,
    inout  wire                  sda,
    output logic                 scl,
    output i2c_pkg::data_byte_t  rdata,
    output logic                 busy,
    output logic                 done,
    output logic                 ack_error
);

    logic               run;
    logic               tick;
    logic               tx_bit;
    logic               sda_in;
    i2c_pkg::phase_t    phase;
    i2c_pkg::bus_cond_t cond;

    // Quarter-bit timing, only runs during a transaction
    i2c_bit_timer timer_i (
        .clk   (clk),
        .rst   (rst),
        .run   (run),
        .tick  (tick),
        .phase (phase)
    );

    i2c_byte_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rw         (rw),
        .slave_addr (slave_addr),
        .wdata      (wdata),
        .tick       (tick),
        .phase      (phase),
        .sda_in     (sda_in),
        .run        (run),
        .cond       (cond),
        .tx_bit     (tx_bit),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error)
    );

    // Pin side: SCL push-pull, SDA open drain
    i2c_line_driver line_i (
        .clk    (clk),
        .rst    (rst),
        .cond   (cond),
        .phase  (phase),
        .tx_bit (tx_bit),
        .scl    (scl),
        .sda    (sda),
        .sda_in (sda_in)
    );

endmodule

// ==== testbench/i2c_master_props.sv ====
`timescale 1ns/100ps

module i2c_master_props (
    input logic               clk,
    input logic               rst,
    input logic               scl,
    input logic               sda,
    input logic               busy,
    input logic               done,
    input i2c_pkg::bus_cond_t cond
);

    int unsigned fail_count = 0;

    // A done pulse closes a transaction that was running
    done_after_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
        else begin
            $error("done pulsed without busy in the cycle before");
            fail_count++;
        end

    idle_lines_high: assert property (@(posedge clk) disable iff (rst) !busy |-> (scl && sda))
        else begin
            $error("SCL or SDA low while the master is idle");
            fail_count++;
        end

    // Line levels lag the request by one register stage
    sda_framed_only: assert property (@(posedge clk) disable iff (rst)
        (scl && $past(scl) && (sda != $past(sda))) |->
            ($past(cond) == i2c_pkg::cond_start || $past(cond) == i2c_pkg::cond_stop))
        else begin
            $error("SDA moved while SCL was high outside a START or STOP slot");
            fail_count++;
        end

endmodule

bind i2c_master_top i2c_master_props props_i (
    .clk  (clk),
    .rst  (rst),
    .scl  (scl),
    .sda  (sda),
    .busy (busy),
    .done (done),
    .cond (cond)
);

// ==== testbench/i2c_master_checker.sv ====
`timescale 1ns/100ps

module i2c_master_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 rw,
    input  i2c_pkg::slave_addr_t slave_addr,
    input  i2c_pkg::data_byte_t  wdata,
    input  logic                 exp_ack_error, // Expected status of the current row
    input  logic                 scl,
    input  logic                 sda,
    input  i2c_pkg::data_byte_t  rdata,
    input  logic                 busy,
    input  logic                 done,
    input  logic                 ack_error,
    input  i2c_pkg::data_byte_t  slave_reg,     // Register inside the slave model
    output int unsigned          error_count,
    output int unsigned          accepted_count,
    output int unsigned          done_count
);

    i2c_pkg::data_byte_t  model_reg; // Expected slave register
    i2c_pkg::data_byte_t  wdata_q;
    logic                 rw_q;
    logic                 exp_ack_q;
    logic                 pending;   // Accepted start still waiting for done
    logic                 seen_start;

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected 8'h%02h, got 8'h%02h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Reset state of the ports before anything is requested
    task automatic check_idle();
        compare_value("done", 8'h00, {7'b0, done});
        compare_value("ack_error", 8'h00, {7'b0, ack_error});
        compare_value("rdata", 8'h00, rdata);
        compare_value("scl", 8'h01, {7'b0, scl});
        compare_value("sda", 8'h01, {7'b0, sda});
    endtask

    task automatic check_result();
        done_count++;
        if (!pending) begin
            $display("Unexpected done pulse at time %0t with no accepted start open", $time);
            error_count++;
        end else begin
            compare_value("ack_error", {7'b0, exp_ack_q}, {7'b0, ack_error});
            if (!exp_ack_q && !rw_q) begin
                model_reg = wdata_q; // Acknowledged write lands in the slave
            end
            if (!exp_ack_q && rw_q) begin
                compare_value("rdata", model_reg, rdata);
            end
            compare_value("slave_reg", model_reg, slave_reg);
        end
        pending = 1'b0;
    endtask

    task automatic accept_request();
        accepted_count++;
        pending    = 1'b1;
        seen_start = 1'b1;
        rw_q       = rw;
        wdata_q    = wdata;
        exp_ack_q  = exp_ack_error;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_reg      = 8'hA5;
            pending        = 1'b0;
            seen_start     = 1'b0;
            error_count    = 0;
            accepted_count = 0;
            done_count     = 0;
        end else begin
            if (!seen_start) begin
                check_idle();
            end
            if (done) begin
                check_result();
            end
            // Busy from the cycle after acceptance until done
            compare_value("busy", {7'b0, pending}, {7'b0, busy});
            if (start && !pending) begin
                accept_request(); // Starts while busy are dropped by the DUT
            end
        end
    end

endmodule

// ==== testbench/i2c_master_tb.sv ====
`timescale 1ns/100ps

module i2c_master_tb;

    localparam i2c_pkg::slave_addr_t own_addr = 7'h3A; // Slave model address
    localparam int unsigned num_rows = 10;
    localparam int unsigned timeout_cycles = num_rows * 21 * 4 * i2c_pkg::quarter_div + 1000;

    typedef struct packed {
        logic                 rw;
        i2c_pkg::slave_addr_t addr;
        i2c_pkg::data_byte_t  wdata;
        logic                 use_lcg;       // Take the data from the LCG instead
        logic                 again;         // Second start while busy
        logic                 exp_ack_error;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 start;
    logic                 rw;
    i2c_pkg::slave_addr_t slave_addr;
    i2c_pkg::data_byte_t  wdata;
    wire                  sda;
    logic                 scl;
    i2c_pkg::data_byte_t  rdata;
    logic                 busy;
    logic                 done;
    logic                 ack_error;
    logic                 exp_ack_error;
    int unsigned          cycles = 0;
    int unsigned          tb_errors = 0;
    int unsigned          check_errors;
    int unsigned          accepted_cnt;
    int unsigned          done_cnt;
    logic [31:0]          lcg_state = 32'h20e1_7de3;
    row_t                 rows [num_rows];

    // Slave model
    logic                 slave_low;
    logic                 scl_q;
    logic                 sda_q;
    logic                 active;
    logic                 addressed;
    logic                 reading;
    logic                 byte_no;   // 0 address, 1 data
    logic [3:0]           bits;      // SCL rising edges in the current byte
    i2c_pkg::data_byte_t  rx_shift;
    i2c_pkg::data_byte_t  tx_shift;
    i2c_pkg::data_byte_t  slave_reg;

    always #10 clk = ~clk;

    pullup (sda);
    assign sda = slave_low ? 1'b0 : 1'bz;

    i2c_master_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rw         (rw),
        .slave_addr (slave_addr),
        .wdata      (wdata),
        .sda        (sda),
        .scl        (scl),
        .rdata      (rdata),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error)
    );

    i2c_master_checker checker_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .rw             (rw),
        .slave_addr     (slave_addr),
        .wdata          (wdata),
        .exp_ack_error  (exp_ack_error),
        .scl            (scl),
        .sda            (sda),
        .rdata          (rdata),
        .busy           (busy),
        .done           (done),
        .ack_error      (ack_error),
        .slave_reg      (slave_reg),
        .error_count    (check_errors),
        .accepted_count (accepted_cnt),
        .done_count     (done_cnt)
    );

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            slave_low <= 1'b0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            active    <= 1'b0;
            addressed <= 1'b0;
            reading   <= 1'b0;
            byte_no   <= 1'b0;
            bits      <= 4'd0;
            rx_shift  <= 8'h00;
            tx_shift  <= 8'h00;
            slave_reg <= 8'hA5;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin // START
                active    <= 1'b1;
                addressed <= 1'b0;
                byte_no   <= 1'b0;
                bits      <= 4'd0;
                slave_low <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin // STOP
                active    <= 1'b0;
                slave_low <= 1'b0;
            end else if (active && scl && !scl_q) begin
                if (bits < 4'd8) begin
                    rx_shift <= {rx_shift[6:0], sda};
                end
                bits <= bits + 4'd1;
            end else if (active && !scl && scl_q) begin
                // Drive changes only while SCL is low
                if (bits == 4'd8) begin
                    if (!byte_no) begin
                        addressed <= (rx_shift[7:1] == own_addr);
                        reading   <= rx_shift[0];
                        slave_low <= (rx_shift[7:1] == own_addr);
                    end else if (addressed && !reading) begin
                        slave_reg <= rx_shift;
                        slave_low <= 1'b1;
                    end else begin
                        slave_low <= 1'b0; // Master answers the read byte
                    end
                end else if (bits == 4'd9) begin
                    bits      <= 4'd0;
                    byte_no   <= 1'b1;
                    slave_low <= 1'b0;
                    if (!byte_no && addressed && reading) begin
                        tx_shift  <= slave_reg;
                        slave_low <= !slave_reg[7];
                    end
                end else if (byte_no && addressed && reading && bits != 4'd0) begin
                    tx_shift  <= {tx_shift[6:0], 1'b0};
                    slave_low <= !tx_shift[6];
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_table();
        //         rw    addr   wdata  lcg   again exp_ack_error
        rows[0] = '{1'b1, 7'h3A, 8'h00, 1'b0, 1'b0, 1'b0}; // Nothing written yet
        rows[1] = '{1'b0, 7'h3A, 8'h00, 1'b1, 1'b0, 1'b0};
        rows[2] = '{1'b1, 7'h3A, 8'h00, 1'b0, 1'b0, 1'b0};
        rows[3] = '{1'b0, 7'h51, 8'h3C, 1'b0, 1'b0, 1'b1}; // No slave there
        rows[4] = '{1'b1, 7'h3A, 8'h00, 1'b0, 1'b0, 1'b0};
        rows[5] = '{1'b0, 7'h3A, 8'h00, 1'b1, 1'b1, 1'b0};
        rows[6] = '{1'b1, 7'h3B, 8'h00, 1'b0, 1'b0, 1'b1};
        rows[7] = '{1'b1, 7'h3A, 8'h00, 1'b0, 1'b1, 1'b0};
        rows[8] = '{1'b0, 7'h3A, 8'h5A, 1'b0, 1'b0, 1'b0};
        rows[9] = '{1'b1, 7'h3A, 8'h00, 1'b0, 1'b0, 1'b0};
    endtask

    task automatic apply_row(input row_t row);
        i2c_pkg::data_byte_t data;
        data = row.wdata;
        if (row.use_lcg) begin
            lcg_state = lcg_next(lcg_state);
            data = lcg_state[23:16];
        end
        rw = row.rw;
        slave_addr = row.addr;
        wdata = data;
        exp_ack_error = row.exp_ack_error;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (row.again) begin
            repeat (200) @(negedge clk);
            rw = !row.rw; // Must be ignored
            slave_addr = ~row.addr;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_run();
        int unsigned total;
        if (accepted_cnt != num_rows || done_cnt != num_rows) begin
            $display("Transaction count wrong: %0d rows, %0d accepted starts, %0d done pulses",
                     num_rows, accepted_cnt, done_cnt);
            tb_errors++;
        end
        total = tb_errors + check_errors + dut_i.props_i.fail_count;
        $display("Errors: %0d checker, %0d assertion, %0d testbench; %0d transactions done",
                 check_errors, dut_i.props_i.fail_count, tb_errors, done_cnt);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        rw = 1'b0;
        slave_addr = '0;
        wdata = '0;
        exp_ack_error = 1'b0;
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        repeat (10) @(negedge clk);
        finish_run();
    end

    // Bound on the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout after %0d cycles: %0d transactions done, %0d checker errors",
                     cycles, done_cnt, check_errors);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// ==== i2c_master.f ====
src/i2c_pkg.sv
src/i2c_bit_timer.sv
src/i2c_byte_sequencer.sv
src/i2c_line_driver.sv
src/i2c_master_top.sv
testbench/i2c_master_props.sv
testbench/i2c_master_checker.sv
testbench/i2c_master_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = i2c_master_tb
FILELIST   = i2c_master.f
OBJ_DIR    = obj_dir
SIM_ARGS   = +verilator+error+limit+100
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | \
		awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
